// File: source/mem_bus_pkg.sv
// Word bus definitions
// Widths, operation and response encodings, ROM signature

package mem_bus_pkg;

  localparam int unsigned DataWidth = 64;
  localparam int unsigned AddrWidth = 32;   // Byte address
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Host operation
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } bus_op_e;

  // Response code of an access
  typedef enum logic [1:0] {
    RESP_OKAY,
    RESP_SLVERR,
    RESP_DECERR
  } bus_resp_e;

  // Upper half of every boot ROM word
  localparam logic [31:0] RomSignature = 32'h5EED_B007;

endpackage

// File: source/soc_map_pkg.sv
// Address map of the subsystem
// Window bases and lengths, exit address and region encoding

package soc_map_pkg;
  import mem_bus_pkg::*;

  // ------------------------------
  // Regions
  // ------------------------------
  typedef enum logic [1:0] {
    REG_ROM,
    REG_GPIO,
    REG_DRAM,
    REG_NONE   // No rule matched
  } region_e;

  // ------------------------------
  // Boot ROM
  // ------------------------------
  localparam logic [AddrWidth-1:0] RomBase  = 32'h0001_0000;
  localparam int unsigned          RomWords = 64;

  // ------------------------------
  // Unimplemented GPIO window
  // ------------------------------
  localparam logic [AddrWidth-1:0] GpioBase   = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength = 32'h0000_1000;

  // ------------------------------
  // Main RAM
  // ------------------------------
  // The length follows the RAM depth, which is a top level parameter
  localparam logic [AddrWidth-1:0] DramBase = 32'h8000_0000;

  // A write here sets the exit code
  localparam logic [AddrWidth-1:0] ExitAddr = DramBase;

endpackage

// File: source/mem_port_if.sv
// Single-beat word port from the decoder to a memory target
// A one-cycle req pulse with rdata a cycle later and no handshake

interface mem_port_if import mem_bus_pkg::*; #(
  parameter int unsigned IdxWidth = 6   // Word index width of the target
) ();

  logic                 req;       // One-cycle access strobe
  logic                 we;
  logic [IdxWidth-1:0]  word_idx;  // Word offset inside the window
  logic [BeWidth-1:0]   be;
  logic [DataWidth-1:0] wdata;
  logic [DataWidth-1:0] rdata;     // Registered in the target

  // Decoder side
  modport initiator (
    output req,
    output we,
    output word_idx,
    output be,
    output wdata,
    input  rdata
  );

  // Memory side
  modport target (
    input  req,
    input  we,
    input  word_idx,
    input  be,
    input  wdata,
    output rdata
  );

endinterface

// File: source/addr_decoder.sv
// Host req/ack handshake, rule table decode and error responder
// Routes one access at a time to the boot ROM or the main RAM

module addr_decoder import mem_bus_pkg::*; import soc_map_pkg::*; #(
  parameter int unsigned RamWords = 1024
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  bus_op_e              op_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 ack_o,
  output logic [DataWidth-1:0] rdata_o,
  output bus_resp_e            resp_o,
  mem_port_if.initiator        rom_o,
  mem_port_if.initiator        ram_o
);

  localparam int unsigned RomIdxW  = $clog2(RomWords);
  localparam int unsigned RamIdxW  = $clog2(RamWords);
  localparam int unsigned NumRules = 3;

  typedef enum logic [1:0] {IDLE, ACCESS, RESPOND, RELEASE} state_e;

  typedef struct packed {
    region_e              region;
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;    // Exclusive
  } addr_rule_t;

  localparam addr_rule_t [NumRules-1:0] AddrMap = '{
    '{REG_DRAM, DramBase, DramBase + AddrWidth'(RamWords * 8)},
    '{REG_GPIO, GpioBase, GpioBase + GpioLength},
    '{REG_ROM,  RomBase,  RomBase + AddrWidth'(RomWords * 8)}
  };

  state_e                 state_d, state_q;
  region_e                region_d, region_q;
  logic                   access_d, access_q;  // Needs a port access
  bus_resp_e              resp_d, resp_q;
  logic [AddrWidth-1:0]   offset_d;
  logic [AddrWidth-4:0]   word_q;
  logic                   we_q;
  logic [BeWidth-1:0]     be_q;
  logic [DataWidth-1:0]   wdata_q, rdata_q;

  // ------------------------------
  // Decode
  // ------------------------------
  always_comb begin : p_decode
    logic [AddrWidth-1:0] addr_aligned;
    addr_aligned = {addr_i[AddrWidth-1:3], 3'b000};  // Low bits ignored
    region_d     = REG_NONE;
    offset_d     = '0;
    for (int i = 0; i < NumRules; i++) begin
      if (addr_aligned >= AddrMap[i].start_addr && addr_aligned < AddrMap[i].end_addr) begin
        region_d = AddrMap[i].region;
        offset_d = addr_aligned - AddrMap[i].start_addr;
      end
    end
    unique case (region_d)
      REG_ROM: begin
        access_d = (op_i == OP_READ);           // ROM writes rejected here
        resp_d   = access_d ? RESP_OKAY : RESP_SLVERR;
      end
      REG_DRAM: begin
        access_d = 1'b1;
        resp_d   = RESP_OKAY;
      end
      REG_GPIO: begin
        access_d = 1'b0;
        resp_d   = RESP_SLVERR;
      end
      default: begin
        access_d = 1'b0;
        resp_d   = RESP_DECERR;
      end
    endcase
  end

  // ------------------------------
  // Handshake FSM
  // ------------------------------
  always_comb begin : p_fsm
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (req_i) state_d = access_d ? ACCESS : RESPOND;
      ACCESS:  state_d = RESPOND;            // Port pulse, target reads
      RESPOND: state_d = RELEASE;            // Data captured
      RELEASE: if (!req_i) state_d = IDLE;   // Hold until host lets go
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      state_q  <= IDLE;
      region_q <= REG_NONE;
      access_q <= 1'b0;
      resp_q   <= RESP_OKAY;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && req_i) begin
        region_q <= region_d;
        access_q <= access_d;
        resp_q   <= resp_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (state_q == IDLE && req_i) begin
      word_q  <= offset_d[AddrWidth-1:3];
      we_q    <= (op_i == OP_WRITE);
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
    if (state_q == RESPOND) begin
      if (!access_q)                rdata_q <= '0;  // Error responder data
      else if (region_q == REG_ROM) rdata_q <= rom_o.rdata;
      else                          rdata_q <= ram_o.rdata;
    end
  end

  // ------------------------------
  // Target ports
  // ------------------------------
  assign rom_o.req      = (state_q == ACCESS) && (region_q == REG_ROM);
  assign rom_o.we       = 1'b0;   // Read only
  assign rom_o.word_idx = word_q[RomIdxW-1:0];
  assign rom_o.be       = '0;
  assign rom_o.wdata    = '0;

  assign ram_o.req      = (state_q == ACCESS) && (region_q == REG_DRAM);
  assign ram_o.we       = we_q;
  assign ram_o.word_idx = word_q[RamIdxW-1:0];
  assign ram_o.be       = be_q;
  assign ram_o.wdata    = wdata_q;

  assign ack_o   = (state_q == RELEASE);
  assign rdata_o = rdata_q;
  assign resp_o  = resp_q;

endmodule

// File: source/boot_rom.sv
// Boot ROM with rule-generated contents
// Each word is the signature above the word index

module boot_rom import mem_bus_pkg::*; import soc_map_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  mem_port_if.target bus_i
);

  logic [DataWidth-1:0] rom_table [RomWords];
  logic [DataWidth-1:0] rdata_q;

  // ------------------------------
  // Contents
  // ------------------------------
  for (genvar i = 0; i < RomWords; i++) begin : gen_word
    assign rom_table[i] = {RomSignature, 32'(i)};
  end

  // ------------------------------
  // Read port
  // ------------------------------
  // Writes are rejected by the decoder and never pulse req here
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (bus_i.req) begin
      rdata_q <= rom_table[bus_i.word_idx];  // Valid the cycle after req
    end
  end

  assign bus_i.rdata = rdata_q;

endmodule

// File: source/main_ram.sv
// Main RAM with byte enables and registered reads
// Also captures the exit code on a write to the exit address

module main_ram import mem_bus_pkg::*; import soc_map_pkg::*; #(
  parameter int unsigned RamWords = 1024
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  mem_port_if.target  bus_i,
  output logic [31:0] exit_o
);

  // Word index of the exit address inside the window
  localparam logic [AddrWidth-1:0] ExitIdx = (ExitAddr - DramBase) >> 3;

  logic [DataWidth-1:0] mem_q [RamWords];
  logic [DataWidth-1:0] rdata_q;
  logic [31:0]          exit_q;
  logic                 exit_hit;

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk_i) begin : p_mem
    if (bus_i.req) begin
      if (bus_i.we) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (bus_i.be[b]) mem_q[bus_i.word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end else begin
        rdata_q <= mem_q[bus_i.word_idx];
      end
    end
  end

  assign bus_i.rdata = rdata_q;

  // ------------------------------
  // Exit code
  // ------------------------------
  assign exit_hit = bus_i.req && bus_i.we && (AddrWidth'(bus_i.word_idx) == ExitIdx);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_exit
    if (!rst_ni) begin
      exit_q <= '0;
    end else if (exit_hit) begin
      exit_q <= bus_i.wdata[31:0];  // Byte enables do not apply
    end
  end

  assign exit_o = exit_q;

endmodule

// File: source/soc_harness_top.sv
// Top level of the memory subsystem
// Host port, decoder, boot ROM and main RAM

module soc_harness_top import mem_bus_pkg::*; import soc_map_pkg::*; #(
  parameter int unsigned RamWords = 1024   // Power of two
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  bus_op_e              op_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 ack_o,
  output logic [DataWidth-1:0] rdata_o,
  output bus_resp_e            resp_o,
  output logic [31:0]          exit_o
);

  // ------------------------------
  // Target ports
  // ------------------------------
  mem_port_if #(.IdxWidth($clog2(RomWords))) rom_port ();
  mem_port_if #(.IdxWidth($clog2(RamWords))) ram_port ();

  // ------------------------------
  // Decoder
  // ------------------------------
  addr_decoder #(
    .RamWords ( RamWords )
  ) i_addr_decoder (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .req_i   ( req_i    ),
    .op_i    ( op_i     ),
    .addr_i  ( addr_i   ),
    .be_i    ( be_i     ),
    .wdata_i ( wdata_i  ),
    .ack_o   ( ack_o    ),
    .rdata_o ( rdata_o  ),
    .resp_o  ( resp_o   ),
    .rom_o   ( rom_port ),
    .ram_o   ( ram_port )
  );

  // ------------------------------
  // Memories
  // ------------------------------
  boot_rom i_boot_rom (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .bus_i  ( rom_port )
  );

  main_ram #(
    .RamWords ( RamWords )
  ) i_main_ram (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .bus_i  ( ram_port ),
    .exit_o ( exit_o   )   // Exit code register
  );

endmodule

// File: test/soc_harness_props.sv
// Handshake assertions for the host port
// Bound into the subsystem top level

module soc_harness_props import mem_bus_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_i,
  input logic                 ack_o,
  input logic [DataWidth-1:0] rdata_o,
  input bus_resp_e            resp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;   // Read by the testbench

  // ------------------------------
  // Properties
  // ------------------------------
  // The rise is seen one edge late, so req_i is taken from the rising edge
  property ack_rise_p;
    @(posedge clk_i) disable iff (!rst_ni) $rose(ack_o) |-> $past(req_i);
  endproperty

  property ack_fall_p;
    @(posedge clk_i) disable iff (!rst_ni) $fell(ack_o) |-> !$past(req_i);
  endproperty

  property ack_hold_p;
    @(posedge clk_i) disable iff (!rst_ni) (ack_o && req_i) |=> ack_o;
  endproperty

  // Response frozen while the host holds it
  property resp_stable_p;
    @(posedge clk_i) disable iff (!rst_ni)
      (ack_o && $past(ack_o)) |-> ($stable(rdata_o) && $stable(resp_o));
  endproperty

  ack_rise_a: assert property (ack_rise_p) else begin
    fail_count++;
    $error("ack_o rose while req_i was low");
  end

  ack_fall_a: assert property (ack_fall_p) else begin
    fail_count++;
    $error("ack_o fell before req_i was released");
  end

  ack_hold_a: assert property (ack_hold_p) else begin
    fail_count++;
    $error("ack_o dropped while req_i was still high");
  end

  resp_stable_a: assert property (resp_stable_p) else begin
    fail_count++;
    $error("rdata_o or resp_o changed while ack_o was high");
  end

endmodule

bind soc_harness_top soc_harness_props i_props (
  .clk_i   ( clk_i   ),
  .rst_ni  ( rst_ni  ),
  .req_i   ( req_i   ),
  .ack_o   ( ack_o   ),
  .rdata_o ( rdata_o ),
  .resp_o  ( resp_o  )
);

// File: test/tb_soc_harness.sv
// Testbench for the memory subsystem
// Host driver, shadow memory model, response checker and timeout

module tb_soc_harness import mem_bus_pkg::*; import soc_map_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned RamWords      = 1024;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned NumRand       = 16;
  localparam int unsigned NumAccesses   = 1 + 6 + 3 * NumRand + 8 + 4;
  localparam int unsigned TimeoutCycles = 2 * (ResetCycles + NumAccesses * 8);

  typedef struct packed {
    bus_op_e              op;
    logic [AddrWidth-1:0] addr;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] data;
  } access_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_i;
  bus_op_e              op_i;
  logic [AddrWidth-1:0] addr_i;
  logic [BeWidth-1:0]   be_i;
  logic [DataWidth-1:0] wdata_i;
  logic                 ack_o;
  logic [DataWidth-1:0] rdata_o;
  bus_resp_e            resp_o;
  logic [31:0]          exit_o;

  logic [DataWidth-1:0] shadow_ram [RamWords];
  logic [31:0]          shadow_exit;
  access_t              pending_q [$];   // Issued, not yet answered
  int unsigned          rand_idx [NumRand];
  int                   err_count;
  int                   check_count;
  int                   cycle_count;
  int                   tests_ok;
  int                   tests_bad;
  int                   test_err_base;
  int                   wait_count;
  logic                 ack_prev;

  always #4 clk_i = ~clk_i;

  soc_harness_top #(
    .RamWords ( RamWords )
  ) UUT (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .op_i    ( op_i    ),
    .addr_i  ( addr_i  ),
    .be_i    ( be_i    ),
    .wdata_i ( wdata_i ),
    .ack_o   ( ack_o   ),
    .rdata_o ( rdata_o ),
    .resp_o  ( resp_o  ),
    .exit_o  ( exit_o  )
  );

  task automatic report_error(input string msg);
    err_count++;
    $display("[FAIL] t=%0d ns: %s", $time, msg);
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic void expect_access(
    input  access_t              acc,
    output logic [DataWidth-1:0] rdata,
    output bus_resp_e            resp,
    output logic [31:0]          exit_code,
    output logic                 rdata_defined,  // Write data return is unspecified
    output logic                 mem_access
  );
    logic [AddrWidth-1:0] a;
    int unsigned          idx;
    a             = {acc.addr[AddrWidth-1:3], 3'b000};
    rdata         = '0;
    rdata_defined = 1'b1;
    mem_access    = 1'b0;
    if (a >= RomBase && a < RomBase + RomWords * 8) begin
      idx = (a - RomBase) / 8;
      if (acc.op == OP_READ) begin
        resp       = RESP_OKAY;
        rdata      = {RomSignature, idx};
        mem_access = 1'b1;
      end else begin
        resp = RESP_SLVERR;   // ROM is never written
      end
    end else if (a >= GpioBase && a < GpioBase + GpioLength) begin
      resp = RESP_SLVERR;
    end else if (a >= DramBase && a < DramBase + RamWords * 8) begin
      idx        = (a - DramBase) / 8;
      resp       = RESP_OKAY;
      mem_access = 1'b1;
      if (acc.op == OP_READ) begin
        rdata = shadow_ram[idx];
      end else begin
        rdata_defined = 1'b0;
        for (int b = 0; b < BeWidth; b++) begin
          if (acc.be[b]) shadow_ram[idx][8*b +: 8] = acc.data[8*b +: 8];
        end
        if (a == ExitAddr) shadow_exit = acc.data[31:0];  // Any byte enables
      end
    end else begin
      resp = RESP_DECERR;
    end
    exit_code = shadow_exit;
  endfunction

  // ------------------------------
  // Response checker
  // ------------------------------
  always @(negedge clk_i) begin : check_access
    access_t              acc;
    logic [DataWidth-1:0] exp_rdata;
    bus_resp_e            exp_resp;
    logic [31:0]          exp_exit;
    logic                 rdata_defined;
    logic                 mem_access;
    if (!rst_ni) begin
      ack_prev   = 1'b0;
      wait_count = 0;
    end else begin
      if (ack_o && !ack_prev) begin
        if (pending_q.size() == 0) begin
          report_error("ack_o rose with no request pending");
        end else begin
          acc = pending_q.pop_front();
          expect_access(acc, exp_rdata, exp_resp, exp_exit, rdata_defined, mem_access);
          check_count++;
          if (rdata_defined && rdata_o !== exp_rdata) begin
            report_error($sformatf("addr %h rdata %h, expected %h",
                                   acc.addr, rdata_o, exp_rdata));
          end
          if (resp_o !== exp_resp) begin
            report_error($sformatf("addr %h resp %0d, expected %0d",
                                   acc.addr, resp_o, exp_resp));
          end
          if (exit_o !== exp_exit) begin
            report_error($sformatf("exit_o %h, expected %h", exit_o, exp_exit));
          end
          // Counts one negedge before the sampling edge
          if (wait_count != (mem_access ? 3 : 2)) begin
            report_error($sformatf("addr %h acked after %0d half cycles of wait",
                                   acc.addr, wait_count));
          end
        end
      end
      if (!req_i) wait_count = 0;
      else if (!ack_o) wait_count++;
      ack_prev = ack_o;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: no finish after %0d clock cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------
  // Host driver
  // ------------------------------
  task automatic run_access(
    input bus_op_e              op,
    input logic [AddrWidth-1:0] addr,
    input logic [BeWidth-1:0]   be,
    input logic [DataWidth-1:0] data,
    input int                   hold   // Extra cycles with req held after ack
  );
    access_t acc;
    acc = '{op, addr, be, data};
    pending_q.push_back(acc);
    op_i    = op;
    addr_i  = addr;
    be_i    = be;
    wdata_i = data;
    req_i   = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (!ack_o);
    repeat (hold) begin
      @(posedge clk_i);
      #1;
      if (!ack_o) report_error("ack_o dropped while req_i was held");
    end
    req_i = 1'b0;
    @(posedge clk_i);
    #1;
    if (ack_o) report_error("ack_o still high one edge after req_i fell");
    while (ack_o) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic end_test(input int num, input string name);
    if (err_count == test_err_base) begin
      tests_ok++;
      $display("[test %0d] %s: ok", num, name);
    end else begin
      tests_bad++;
      $display("[test %0d] %s: %0d errors", num, name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin : stimulus
    int unsigned          rom_idx [6];
    logic [DataWidth-1:0] data;
    int                   k;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    op_i          = OP_READ;
    addr_i        = '0;
    be_i          = '0;
    wdata_i       = '0;
    shadow_exit   = '0;
    err_count     = 0;
    check_count   = 0;
    cycle_count   = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    test_err_base = 0;
    rom_idx       = '{0, 1, 7, 31, 62, 63};
    void'($urandom(32'he2a5edef));
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    if (ack_o !== 1'b0) report_error("ack_o not low after reset");
    if (exit_o !== 32'h0) report_error("exit_o not zero after reset");
    run_access(OP_READ, RomBase + 32'h18, '0, '0, 6);
    end_test(1, "reset state and held request");

    for (k = 0; k < 6; k++) begin
      // Low address bits vary and are ignored
      run_access(OP_READ, RomBase + 8 * rom_idx[k] + rom_idx[k] % 8, '0, '0, 0);
    end
    end_test(2, "boot ROM reads");

    for (k = 0; k < NumRand; k++) begin
      rand_idx[k] = $urandom % RamWords;
      run_access(OP_WRITE, DramBase + 8 * rand_idx[k], '1, {$urandom, $urandom}, 0);
    end
    for (k = 0; k < NumRand; k++) begin
      run_access(OP_WRITE, DramBase + 8 * rand_idx[k], BeWidth'($urandom),
                 {$urandom, $urandom}, 0);
    end
    for (k = 0; k < NumRand; k++) begin
      run_access(OP_READ, DramBase + 8 * rand_idx[k], '0, '0, 0);
    end
    end_test(3, "random RAM writes and reads");

    run_access(OP_WRITE, RomBase + 8 * 5, '1, 64'hDEAD_BEEF_0BAD_F00D, 0);
    run_access(OP_READ, RomBase + 8 * 5, '0, '0, 0);
    run_access(OP_READ, GpioBase + 32'h10, '0, '0, 0);
    run_access(OP_WRITE, GpioBase + GpioLength - 8, '1, 64'h1234_5678_9ABC_DEF0, 0);
    run_access(OP_READ, 32'h0000_0000, '0, '0, 0);
    run_access(OP_READ, RomBase + RomWords * 8, '0, '0, 0);
    run_access(OP_READ, DramBase + RamWords * 8, '0, '0, 0);   // Just past DRAM
    run_access(OP_WRITE, 32'hFFFF_FFF8, '1, 64'h0, 0);
    end_test(4, "error responses");

    data = {$urandom, $urandom};
    run_access(OP_WRITE, ExitAddr, '1, data, 0);
    if (exit_o !== data[31:0]) report_error("exit_o does not hold the written code");
    run_access(OP_READ, ExitAddr, '0, '0, 0);
    run_access(OP_WRITE, ExitAddr, 8'h00, 64'h0000_0000_0000_002A, 0);  // Code only
    run_access(OP_READ, ExitAddr, '0, '0, 0);
    end_test(5, "exit code");

    if (UUT.i_props.fail_count != 0) begin
      err_count += UUT.i_props.fail_count;
      $display("Handshake assertions failed %0d times", UUT.i_props.fail_count);
    end
    $display("Summary: %0d tests ok, %0d with errors, %0d accesses checked, %0d errors",
             tests_ok, tests_bad, check_count, err_count);
    if (err_count == 0 && tests_bad == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: all.f
source/mem_bus_pkg.sv
source/soc_map_pkg.sv
source/mem_port_if.sv
source/addr_decoder.sv
source/boot_rom.sv
source/main_ram.sv
source/soc_harness_top.sv
test/soc_harness_props.sv
test/tb_soc_harness.sv
